// File: gost89_pkg.sv
`default_nettype none

package gost89_pkg;

  // Which way a block goes through the cipher
  typedef enum logic {
    op_encrypt = 1'b0,
    op_decrypt = 1'b1
  } gost_op_e;

  // FIFO that wins when both have a result waiting
  typedef enum logic {
    prio_enc = 1'b0,
    prio_dec = 1'b1
  } arb_state_e;

  parameter int BLOCK_W = 64;
  parameter int HALF_W  = 32;
  parameter int KEY_W   = 256;
  parameter int SBOX_W  = 512;

  parameter int SUBKEYS   = KEY_W / HALF_W;  // Eight 32-bit subkeys, K0 at the top
  parameter int ROUNDS    = 32;
  parameter int NIBBLE_W  = 4;
  parameter int SBOX_ROWS = HALF_W / NIBBLE_W;
  parameter int ROW_W     = SBOX_W / SBOX_ROWS;  // Sixteen 4-bit entries per row
  parameter int ROT_L     = 11;

endpackage

`default_nettype wire

// File: gost89_round.sv
`default_nettype none

module gost89_round (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [gost89_pkg::SBOX_W-1:0] sbox,
  input  logic [gost89_pkg::HALF_W-1:0] subkey,
  input  logic [gost89_pkg::HALF_W-1:0] n1,
  input  logic [gost89_pkg::HALF_W-1:0] n2,
  output logic [gost89_pkg::HALF_W-1:0] out1,
  output logic [gost89_pkg::HALF_W-1:0] out2
);
  import gost89_pkg::*;

  logic [HALF_W-1:0] sum;
  logic [HALF_W-1:0] subst;
  logic [HALF_W-1:0] rotated;

  // Nibble i of the word goes through row i, both counted from the top
  function automatic logic [HALF_W-1:0] sbox_lookup(
    input logic [SBOX_W-1:0] tbl,
    input logic [HALF_W-1:0] x
  );
    logic [HALF_W-1:0]   y;
    logic [NIBBLE_W-1:0] nib;
    y = '0;
    for (int i = 0; i < SBOX_ROWS; i++) begin
      nib = x[HALF_W-1-NIBBLE_W*i -: NIBBLE_W];
      y[HALF_W-1-NIBBLE_W*i -: NIBBLE_W] = tbl[SBOX_W-1-ROW_W*i-NIBBLE_W*nib -: NIBBLE_W];
    end
    return y;
  endfunction

  assign sum     = n1 + subkey;  // Wraps modulo 2^32
  assign subst   = sbox_lookup(sbox, sum);
  assign rotated = {subst[HALF_W-1-ROT_L:0], subst[HALF_W-1:HALF_W-ROT_L]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out1 <= '0;
      out2 <= '0;
    end else begin
      out1 <= rotated ^ n2;
      out2 <= n1;  // Halves swap for the next round
    end
  end

endmodule

`default_nettype wire

// File: gost89_ecb_pipeline.sv
`default_nettype none

module gost89_ecb_pipeline #(
  parameter gost89_pkg::gost_op_e OP    = gost89_pkg::op_encrypt,
  parameter int                   TAG_W = 8
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  gost89_pkg::gost_op_e           in_op,
  input  logic [gost89_pkg::BLOCK_W-1:0] in_data,
  input  logic [TAG_W-1:0]               in_tag,
  input  logic [gost89_pkg::KEY_W-1:0]   key,
  input  logic [gost89_pkg::SBOX_W-1:0]  sbox,
  output logic                           res_valid,
  output logic [gost89_pkg::BLOCK_W-1:0] res_data,
  output logic [TAG_W-1:0]               res_tag
);
  import gost89_pkg::*;

  logic              accept;
  logic [HALF_W-1:0] n1_in_q;
  logic [HALF_W-1:0] n2_in_q;
  logic [HALF_W-1:0] out1_s [ROUNDS];
  logic [HALF_W-1:0] out2_s [ROUNDS];
  logic [ROUNDS:0]   valid_q;  // Bit 0 is the input register, bit k follows round k-1
  logic [TAG_W-1:0]  tag_q [ROUNDS+1];

  // Encryption runs the forward order three times, decryption only once
  function automatic int subkey_index(input int r);
    int fwd_rounds;
    fwd_rounds = (OP == op_encrypt) ? 3 * SUBKEYS : SUBKEYS;
    if (r < fwd_rounds) begin
      return r % SUBKEYS;
    end
    return SUBKEYS - 1 - (r % SUBKEYS);
  endfunction

  assign accept = in_valid && (in_op == OP);

  always_ff @(posedge clk) begin
    if (accept) begin
      n1_in_q <= in_data[BLOCK_W-1:HALF_W];
      n2_in_q <= in_data[HALF_W-1:0];
      tag_q[0] <= in_tag;
    end
    for (int k = 1; k <= ROUNDS; k++) begin
      tag_q[k] <= tag_q[k-1];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[ROUNDS-1:0], accept};
    end
  end

  for (genvar r = 0; r < ROUNDS; r++) begin : g_round
    localparam int KIDX = subkey_index(r);

    if (r == 0) begin : g_first
      gost89_round round_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .sbox   (sbox),
        .subkey (key[KEY_W-1-HALF_W*KIDX -: HALF_W]),
        .n1     (n1_in_q),
        .n2     (n2_in_q),
        .out1   (out1_s[r]),
        .out2   (out2_s[r])
      );
    end else begin : g_next
      gost89_round round_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .sbox   (sbox),
        .subkey (key[KEY_W-1-HALF_W*KIDX -: HALF_W]),
        .n1     (out1_s[r-1]),
        .n2     (out2_s[r-1]),
        .out1   (out1_s[r]),
        .out2   (out2_s[r])
      );
    end
  end

  assign res_valid = valid_q[ROUNDS];
  assign res_data  = {out2_s[ROUNDS-1], out1_s[ROUNDS-1]};
  assign res_tag   = tag_q[ROUNDS];

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(res_valid));

endmodule

`default_nettype wire

// File: gost89_result_fifo.sv
`default_nettype none

module gost89_result_fifo #(
  parameter int DEPTH = 4,
  parameter int TAG_W = 8
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           push,
  input  logic [gost89_pkg::BLOCK_W-1:0] push_data,
  input  logic [TAG_W-1:0]               push_tag,
  input  logic                           pop,
  output logic                           empty,
  output logic [gost89_pkg::BLOCK_W-1:0] head_data,
  output logic [TAG_W-1:0]               head_tag
);
  import gost89_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [BLOCK_W-1:0] data_mem [DEPTH];
  logic [TAG_W-1:0]   tag_mem [DEPTH];
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   wr_ptr;
  logic [CNT_W-1:0]   count;
  logic               full;

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign head_data = data_mem[rd_ptr];
  assign head_tag  = tag_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= push_data;
      tag_mem[wr_ptr]  <= push_tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Upstream credits must keep a free slot for every block in flight
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

// File: gost89_result_arbiter.sv
`default_nettype none

module gost89_result_arbiter #(
  parameter int OUT_CREDITS = 2,
  parameter int TAG_W       = 8
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           enc_empty,
  input  logic [gost89_pkg::BLOCK_W-1:0] enc_data,
  input  logic [TAG_W-1:0]               enc_tag,
  input  logic                           dec_empty,
  input  logic [gost89_pkg::BLOCK_W-1:0] dec_data,
  input  logic [TAG_W-1:0]               dec_tag,
  output logic                           enc_pop,
  output logic                           dec_pop,
  input  logic                           out_credit,
  output logic                           out_valid,
  output gost89_pkg::gost_op_e           out_op,
  output logic [gost89_pkg::BLOCK_W-1:0] out_data,
  output logic [TAG_W-1:0]               out_tag,
  output logic                           in_credit_enc,
  output logic                           in_credit_dec
);
  import gost89_pkg::*;

  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  logic [CRED_W-1:0] credits_q;
  logic              have_credit;
  arb_state_e        prio_q;

  assign have_credit = (credits_q != '0);

  always_comb begin
    enc_pop = 1'b0;
    dec_pop = 1'b0;
    if (have_credit) begin
      if (!enc_empty && !dec_empty) begin  // Both waiting, the priority decides
        enc_pop = (prio_q == prio_enc);
        dec_pop = (prio_q == prio_dec);
      end else begin
        enc_pop = !enc_empty;
        dec_pop = !dec_empty;
      end
    end
  end

  assign out_valid = enc_pop || dec_pop;
  assign out_op    = dec_pop ? op_decrypt : op_encrypt;
  assign out_data  = dec_pop ? dec_data : enc_data;
  assign out_tag   = dec_pop ? dec_tag : enc_tag;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits_q     <= CRED_W'(OUT_CREDITS);
      prio_q        <= prio_enc;
      in_credit_enc <= 1'b0;
      in_credit_dec <= 1'b0;
    end else begin
      case ({out_valid, out_credit})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase

      // The FIFO just served goes to the back of the line
      if (enc_pop) begin
        prio_q <= prio_dec;
      end else if (dec_pop) begin
        prio_q <= prio_enc;
      end

      in_credit_enc <= enc_pop;  // A freed FIFO slot goes back to the sender
      in_credit_dec <= dec_pop;
    end
  end

  // The sink may not return more credits than it was handed
  a_credit_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    (credits_q == CRED_W'(OUT_CREDITS) && !out_valid) |-> !out_credit);

endmodule

`default_nettype wire

// File: gost89_ecb_top.sv
`default_nettype none

module gost89_ecb_top #(
  parameter int TAG_W       = 8,
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [gost89_pkg::KEY_W-1:0]   key,
  input  logic [gost89_pkg::SBOX_W-1:0]  sbox,
  input  logic                           in_valid,
  input  gost89_pkg::gost_op_e           in_op,
  input  logic [gost89_pkg::BLOCK_W-1:0] in_data,
  input  logic [TAG_W-1:0]               in_tag,
  output logic                           in_credit_enc,
  output logic                           in_credit_dec,
  output logic                           out_valid,
  output gost89_pkg::gost_op_e           out_op,
  output logic [gost89_pkg::BLOCK_W-1:0] out_data,
  output logic [TAG_W-1:0]               out_tag,
  input  logic                           out_credit
);
  import gost89_pkg::*;

  logic               enc_res_valid;
  logic [BLOCK_W-1:0] enc_res_data;
  logic [TAG_W-1:0]   enc_res_tag;
  logic               dec_res_valid;
  logic [BLOCK_W-1:0] dec_res_data;
  logic [TAG_W-1:0]   dec_res_tag;

  logic               enc_empty;
  logic [BLOCK_W-1:0] enc_head_data;
  logic [TAG_W-1:0]   enc_head_tag;
  logic               enc_pop;
  logic               dec_empty;
  logic [BLOCK_W-1:0] dec_head_data;
  logic [TAG_W-1:0]   dec_head_tag;
  logic               dec_pop;

  // Both pipelines see every block and keep only their own opcode
  gost89_ecb_pipeline #(.OP(op_encrypt), .TAG_W(TAG_W)) enc_pipe_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_data   (in_data),
    .in_tag    (in_tag),
    .key       (key),
    .sbox      (sbox),
    .res_valid (enc_res_valid),
    .res_data  (enc_res_data),
    .res_tag   (enc_res_tag)
  );

  gost89_ecb_pipeline #(.OP(op_decrypt), .TAG_W(TAG_W)) dec_pipe_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_data   (in_data),
    .in_tag    (in_tag),
    .key       (key),
    .sbox      (sbox),
    .res_valid (dec_res_valid),
    .res_data  (dec_res_data),
    .res_tag   (dec_res_tag)
  );

  gost89_result_fifo #(.DEPTH(FIFO_DEPTH), .TAG_W(TAG_W)) enc_fifo_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (enc_res_valid),
    .push_data (enc_res_data),
    .push_tag  (enc_res_tag),
    .pop       (enc_pop),
    .empty     (enc_empty),
    .head_data (enc_head_data),
    .head_tag  (enc_head_tag)
  );

  gost89_result_fifo #(.DEPTH(FIFO_DEPTH), .TAG_W(TAG_W)) dec_fifo_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (dec_res_valid),
    .push_data (dec_res_data),
    .push_tag  (dec_res_tag),
    .pop       (dec_pop),
    .empty     (dec_empty),
    .head_data (dec_head_data),
    .head_tag  (dec_head_tag)
  );

  gost89_result_arbiter #(.OUT_CREDITS(OUT_CREDITS), .TAG_W(TAG_W)) arbiter_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .enc_empty     (enc_empty),
    .enc_data      (enc_head_data),
    .enc_tag       (enc_head_tag),
    .dec_empty     (dec_empty),
    .dec_data      (dec_head_data),
    .dec_tag       (dec_head_tag),
    .enc_pop       (enc_pop),
    .dec_pop       (dec_pop),
    .out_credit    (out_credit),
    .out_valid     (out_valid),
    .out_op        (out_op),
    .out_data      (out_data),
    .out_tag       (out_tag),
    .in_credit_enc (in_credit_enc),
    .in_credit_dec (in_credit_dec)
  );

endmodule

`default_nettype wire

// File: tb_gost89_ref.svh
`ifndef TB_GOST89_REF_SVH
`define TB_GOST89_REF_SVH

// Software model of the cipher and the random source, included inside the testbench module

localparam logic [31:0] LFSR_SEED = 32'h0b5a2018;

logic [31:0] lfsr_q;

// Taps 32, 22, 2, 1 of a maximal-length Fibonacci LFSR
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
  lfsr_q = {lfsr_q[30:0], fb};
  return fb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[62:0], lfsr_bit()};
  end
  return v;
endfunction

// Row i of the table replaces nibble i of the word, both counted from the top
function automatic logic [31:0] sbox_subst(input logic [511:0] tbl, input logic [31:0] x);
  logic [63:0] row;
  logic [3:0]  v;
  logic [31:0] y;
  y = '0;
  for (int i = 0; i < 8; i++) begin
    row = tbl[511-64*i -: 64];
    v   = x[31-4*i -: 4];
    y   = {y[27:0], row[63-4*v -: 4]};
  end
  return y;
endfunction

function automatic logic [31:0] round_f(
  input logic [511:0] tbl,
  input logic [31:0]  k,
  input logic [31:0]  n1
);
  logic [31:0] s;
  s = sbox_subst(tbl, n1 + k);
  return (s << 11) | (s >> 21);
endfunction

// The last eight rounds always run K7 down to K0
function automatic int key_index(input gost_op_e op, input int r);
  if (r < 8 || (op == op_encrypt && r < 24)) begin
    return r % 8;
  end
  return 7 - (r % 8);
endfunction

function automatic logic [63:0] gost_cipher(
  input gost_op_e     op,
  input logic [255:0] k,
  input logic [511:0] tbl,
  input logic [63:0]  blk
);
  logic [31:0] n1;
  logic [31:0] n2;
  logic [31:0] t;
  n1 = blk[63:32];
  n2 = blk[31:0];
  for (int r = 0; r < 32; r++) begin
    t  = n1;
    n1 = round_f(tbl, k[255-32*key_index(op, r) -: 32], n1) ^ n2;
    n2 = t;
  end
  return {n2, n1};
endfunction

`endif

// File: tb_gost89_ecb.sv
`default_nettype none

module tb_gost89_ecb;
  timeunit 1ns;
  timeprecision 100ps;

  import gost89_pkg::*;

  localparam int TAG_W       = 8;
  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int MIN_LATENCY = 34;
  localparam int WAIT_LIMIT  = 2000;
  localparam int HOLD_CYCLES = 150;

  logic               clk;
  logic               arst_n;
  logic [KEY_W-1:0]   key;
  logic [SBOX_W-1:0]  sbox;
  logic               in_valid;
  gost_op_e           in_op;
  logic [BLOCK_W-1:0] in_data;
  logic [TAG_W-1:0]   in_tag;
  logic               in_credit_enc;
  logic               in_credit_dec;
  logic               out_valid;
  gost_op_e           out_op;
  logic [BLOCK_W-1:0] out_data;
  logic [TAG_W-1:0]   out_tag;
  logic               out_credit;

  int unsigned        cred_enc;
  int unsigned        cred_dec;
  int unsigned        owed;  // Results the sink took and has not paid back yet
  logic               hold_credits;
  logic [TAG_W-1:0]   next_tag;
  logic [BLOCK_W-1:0] plain_q [$];

  // Expected results per opcode, tag above data
  logic [TAG_W+BLOCK_W-1:0] exp_enc_q [$];
  logic [TAG_W+BLOCK_W-1:0] exp_dec_q [$];

  int unsigned cyc;
  int unsigned sent_enc;
  int unsigned sent_dec;
  int unsigned ret_enc;
  int unsigned ret_dec;
  int unsigned outs;
  int unsigned paid;
  int unsigned acc_enc_q [$];
  int unsigned acc_dec_q [$];

  `include "tb_gost89_ref.svh"

  gost89_ecb_top #(
    .TAG_W       (TAG_W),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) gost89_ecb_top_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .key           (key),
    .sbox          (sbox),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_data       (in_data),
    .in_tag        (in_tag),
    .in_credit_enc (in_credit_enc),
    .in_credit_dec (in_credit_dec),
    .out_valid     (out_valid),
    .out_op        (out_op),
    .out_data      (out_data),
    .out_tag       (out_tag),
    .out_credit    (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("FAIL at %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic give_up_waiting(input string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Test failed");
    $fatal(1, "stopped on a timeout");
  endtask

  // One clock of the sender and the sink together
  task automatic tick();
    @(posedge clk);
    if (in_credit_enc) cred_enc++;
    if (in_credit_dec) cred_dec++;
    if (out_valid) owed++;
    in_valid   <= 1'b0;
    out_credit <= 1'b0;
    if (!hold_credits && owed > 0) begin
      if (lfsr_bit()) begin
        out_credit <= 1'b1;
        owed--;
      end
    end
  endtask

  task automatic drive_block(input gost_op_e op, input logic [63:0] blk, input logic [63:0] want);
    in_valid <= 1'b1;
    in_op    <= op;
    in_data  <= blk;
    in_tag   <= next_tag;
    if (op == op_encrypt) begin
      cred_enc--;
      exp_enc_q.push_back({next_tag, want});
    end else begin
      cred_dec--;
      exp_dec_q.push_back({next_tag, want});
    end
    next_tag++;
  endtask

  task automatic send_block(input gost_op_e op, input logic [63:0] blk, input logic [63:0] want);
    int waited;
    waited = 0;
    tick();
    while ((op == op_encrypt ? cred_enc : cred_dec) == 0) begin
      if (waited == WAIT_LIMIT) give_up_waiting("an upstream credit");
      waited++;
      tick();
    end
    drive_block(op, blk, want);
  endtask

  task automatic check_result();
    logic [TAG_W+BLOCK_W-1:0] want;
    int unsigned              accepted;
    if (out_op == op_encrypt) begin
      assert (exp_enc_q.size() > 0) else fail_now("encryption result with no block outstanding");
      want     = exp_enc_q.pop_front();
      accepted = acc_enc_q.pop_front();
    end else begin
      assert (exp_dec_q.size() > 0) else fail_now("decryption result with no block outstanding");
      want     = exp_dec_q.pop_front();
      accepted = acc_dec_q.pop_front();
    end
    assert (out_tag == want[TAG_W+BLOCK_W-1:BLOCK_W] && out_data == want[BLOCK_W-1:0])
      else fail_now($sformatf("%s result tag %0h data %h, expected tag %0h data %h",
        out_op.name(), out_tag, out_data, want[TAG_W+BLOCK_W-1:BLOCK_W], want[BLOCK_W-1:0]));
    assert (cyc - accepted >= MIN_LATENCY)
      else fail_now($sformatf("result came %0d cycles after its block", cyc - accepted));
  endtask

  // Checker watching both sides of the DUT at every clock edge
  always @(posedge clk) begin
    if (arst_n) begin
      cyc++;
      if (in_valid && in_op == op_encrypt) begin
        sent_enc++;
        acc_enc_q.push_back(cyc);
      end
      if (in_valid && in_op == op_decrypt) begin
        sent_dec++;
        acc_dec_q.push_back(cyc);
      end
      if (in_credit_enc) ret_enc++;
      if (in_credit_dec) ret_dec++;
      assert (ret_enc <= sent_enc && ret_dec <= sent_dec)
        else fail_now("more upstream credits returned than blocks sent");
      if (out_valid) begin
        outs++;
        assert (outs <= OUT_CREDITS + paid)
          else fail_now($sformatf("result %0d sent with only %0d credits granted", outs,
            OUT_CREDITS + paid));
        check_result();
      end
      if (out_credit) paid++;
    end
  end

  initial begin
    gost_op_e           op;
    logic [BLOCK_W-1:0] blk;
    logic [KEY_W-1:0]   key_v;
    logic [SBOX_W-1:0]  sbox_v;
    int                 waited;
    lfsr_q       = LFSR_SEED;
    cred_enc     = FIFO_DEPTH;
    cred_dec     = FIFO_DEPTH;
    owed         = 0;
    hold_credits = 1'b0;
    next_tag     = '0;
    for (int i = 0; i < KEY_W / 64; i++) key_v = {key_v[KEY_W-65:0], rand_bits(64)};
    for (int i = 0; i < SBOX_W / 64; i++) sbox_v = {sbox_v[SBOX_W-65:0], rand_bits(64)};
    arst_n     <= 1'b0;
    key        <= key_v;
    sbox       <= sbox_v;
    in_valid   <= 1'b0;
    in_op      <= op_encrypt;
    in_data    <= '0;
    in_tag     <= '0;
    out_credit <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    tick();
    assert (!out_valid && !in_credit_enc && !in_credit_dec)
      else fail_now("result or credit outputs active right after reset");

    // Mixed traffic with the sink paying credits back at random
    for (int n = 0; n < 48; n++) begin
      op  = rand_bits(1) ? op_decrypt : op_encrypt;
      blk = rand_bits(64);
      if (op == op_encrypt) plain_q.push_back(blk);
      send_block(op, blk, gost_cipher(op, key_v, sbox_v, blk));
      if (rand_bits(2) == 0) tick();
    end

    // Ciphertexts sent back must decrypt to the original plaintext
    while (plain_q.size() > 0) begin
      blk = plain_q.pop_front();
      send_block(op_decrypt, gost_cipher(op_encrypt, key_v, sbox_v, blk), blk);
    end

    // Sink holds its credits, so the FIFOs fill and the sender runs dry
    hold_credits = 1'b1;
    for (int n = 0; n < HOLD_CYCLES; n++) begin
      tick();
      op = rand_bits(1) ? op_decrypt : op_encrypt;
      if ((op == op_encrypt ? cred_enc : cred_dec) > 0) begin
        blk = rand_bits(64);
        drive_block(op, blk, gost_cipher(op, key_v, sbox_v, blk));
      end
    end
    assert (cred_enc == 0 && cred_dec == 0)
      else fail_now("upstream credits did not run out while the sink held back");
    hold_credits = 1'b0;

    waited = 0;
    while (exp_enc_q.size() != 0 || exp_dec_q.size() != 0 ||
           cred_enc != FIFO_DEPTH || cred_dec != FIFO_DEPTH) begin
      if (waited == WAIT_LIMIT) give_up_waiting("the results and credits to drain");
      waited++;
      tick();
    end
    repeat (4) tick();
    assert (ret_enc == sent_enc && ret_dec == sent_dec && cred_enc == FIFO_DEPTH &&
            cred_dec == FIFO_DEPTH)
      else fail_now($sformatf("credits back enc %0d of %0d, dec %0d of %0d",
        ret_enc, sent_enc, ret_dec, sent_dec));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
gost89_pkg.sv
gost89_round.sv
gost89_ecb_pipeline.sv
gost89_result_fifo.sv
gost89_result_arbiter.sv
gost89_ecb_top.sv
tb_gost89_ecb.sv
